// File: Bender.yml
package:
  name: lmem

sources:
  - target: rtl
    files:
      - hw/lmem_pkg.sv
      - hw/lmem_stream_if.sv
      - hw/lmem_xbar.sv
      - hw/lmem_bank.sv
      - hw/lmem_top.sv
  - target: test
    files:
      - bench/lmem_tb.sv

// File: bench/lmem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lmem_tb;

    localparam int NP = 4;
    // Reset and fill cycles plus the operations of every test
    localparam int RUN_OPS = 16 + 256 + 5 + 2 + 5 + 12 + 400;

    logic                   clk;
    logic                   reset;
    logic                   req_valid [NP];
    logic                   req_rw [NP];
    lmem_pkg::lmem_addr_t   req_addr [NP];
    lmem_pkg::lmem_byteen_t req_byteen [NP];
    lmem_pkg::lmem_word_t   req_data [NP];
    lmem_pkg::lmem_tag_t    req_tag [NP];
    logic                   req_ready [NP];
    logic                   rsp_valid [NP];
    lmem_pkg::lmem_word_t   rsp_data [NP];
    lmem_pkg::lmem_tag_t    rsp_tag [NP];
    logic                   rsp_ready [NP];

    lmem_pkg::lmem_word_t model [1024];
    lmem_pkg::lmem_word_t exp_data [NP][256];
    bit                   pending [NP][256];
    lmem_pkg::lmem_tag_t  next_tag [NP];
    int                   issued [NP];
    int                   returned [NP];
    bit                   stall [NP];
    bit                   bp_random;
    logic [31:0]          rng_state = 32'hf7f5;
    string                test_name;
    int                   errors;
    int                   checks;
    int                   tests;
    int                   test_err_base;

    lmem_top #(.NUM_REQS(NP), .NUM_BANKS(4), .WORDS_PER_BANK(256)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Word in the region that only port p writes
    function automatic lmem_pkg::lmem_addr_t port_addr(int p, int bank, logic [31:0] r);
        return {6'b0, 2'(p), r[5:0], 2'(bank)};
    endfunction

    // Initial contents, unique per word address
    function automatic lmem_pkg::lmem_word_t fill_word(input lmem_pkg::lmem_addr_t addr);
        return {addr ^ 16'ha5c3, ~addr};
    endfunction

    always @(posedge clk) begin
        #1;
        for (int p = 0; p < NP; p++) begin
            rsp_ready[p] = !stall[p] && (!bp_random || (next_random() % 4) != 0);
        end
    end

    task automatic issue(input int p, input logic rw, input lmem_pkg::lmem_addr_t addr,
                         input lmem_pkg::lmem_byteen_t be, input lmem_pkg::lmem_word_t data);
        logic accepted;
        accepted      = 1'b0;
        req_valid[p]  = 1'b1;
        req_rw[p]     = rw;
        req_addr[p]   = addr;
        req_byteen[p] = be;
        req_data[p]   = data;
        req_tag[p]    = next_tag[p];
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready[p];
            @(posedge clk);
        end
        if (rw) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    model[addr[9:0]][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end else begin
            exp_data[p][next_tag[p]] = model[addr[9:0]];
            pending[p][next_tag[p]]  = 1'b1;
            issued[p]++;
            next_tag[p]++;
        end
        #1;
        req_valid[p] = 1'b0;
    endtask

    task automatic fill_region(input int p);
        for (int w = 0; w < 256; w++) begin
            issue(p, 1'b1, lmem_pkg::lmem_addr_t'(p * 256 + w), 4'hf,
                  fill_word(lmem_pkg::lmem_addr_t'(p * 256 + w)));
        end
    endtask

    task automatic read_burst(input int p, input int bank, input int n);
        for (int k = 0; k < n; k++) begin
            issue(p, 1'b0, port_addr(p, bank, next_random()), 4'h0, '0);
        end
    endtask

    task automatic random_ops(input int p, input int n);
        logic [31:0] r;
        for (int k = 0; k < n; k++) begin
            r = next_random();
            if (r[8]) begin
                @(posedge clk);
                #1;
            end
            issue(p, r[0], port_addr(p, int'(r[2:1]), r >> 10), r[19:16], next_random());
        end
    endtask

    task automatic wait_idle();
        int busy;
        do begin
            @(posedge clk);
            #1;
            busy = 0;
            for (int p = 0; p < NP; p++) begin
                busy += issued[p] - returned[p];
            end
        end while (busy != 0);
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("%-13s %s", test_name, (errors == test_err_base) ? "ok" : "FAILED");
    endtask

    always @(negedge clk) begin
        for (int p = 0; p < NP; p++) begin
            if (!reset && rsp_valid[p] && rsp_ready[p]) begin
                checks++;
                tag_known_a: assert (pending[p][rsp_tag[p]]) else begin
                    errors++;
                    $display("%s: port %0d returned tag %0h that was not outstanding",
                             test_name, p, rsp_tag[p]);
                end
                data_a: assert (rsp_data[p] === exp_data[p][rsp_tag[p]]) else begin
                    errors++;
                    $display("Error: %s port %0d tag %0h expected %h actual %h", test_name,
                             p, rsp_tag[p], exp_data[p][rsp_tag[p]], rsp_data[p]);
                end
                pending[p][rsp_tag[p]] = 1'b0;
                returned[p]++;
            end
        end
    end

    for (genvar i = 0; i < NP; i++) begin : port_chk
        rsp_hold_a: assert property (@(posedge clk) disable iff (reset)
            rsp_valid[i] && !rsp_ready[i]
            |=> rsp_valid[i] && $stable(rsp_data[i]) && $stable(rsp_tag[i]))
        else begin
            errors++;
            $display("Port %0d dropped or changed a response while it was held", i);
        end
        rsp_reset_a: assert property (@(posedge clk) reset |=> !rsp_valid[i])
        else begin
            errors++;
            $display("Port %0d raised rsp_valid during or right after reset", i);
        end
    end

    initial begin
        reset     = 1'b1;
        bp_random = 1'b0;
        for (int p = 0; p < NP; p++) begin
            req_valid[p]  = 1'b0;
            req_rw[p]     = 1'b0;
            req_addr[p]   = '0;
            req_byteen[p] = '0;
            req_data[p]   = '0;
            req_tag[p]    = '0;
            rsp_ready[p]  = 1'b1;
            next_tag[p]   = '0;
        end
        start_test("reset");
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        end_test();

        start_test("fill");
        fork
            fill_region(0);
            fill_region(1);
            fill_region(2);
            fill_region(3);
        join
        end_test();

        start_test("write_read");
        issue(0, 1'b1, port_addr(0, 1, 5), 4'hf, 32'h1234_5678);
        issue(0, 1'b0, port_addr(0, 1, 5), 4'h0, '0);
        issue(0, 1'b0, port_addr(0, 1, 5), 4'h0, '0);
        issue(0, 1'b1, port_addr(0, 1, 5), 4'b0101, 32'hcafe_f00d);
        issue(0, 1'b0, port_addr(0, 1, 5), 4'h0, '0);
        wait_idle();
        end_test();

        // Read right behind a write to the same word on one port
        start_test("hazard");
        issue(1, 1'b1, port_addr(1, 3, 17), 4'hf, 32'h0bad_f00d);
        issue(1, 1'b0, port_addr(1, 3, 17), 4'h0, '0);
        wait_idle();
        end_test();

        start_test("same_bank");
        issue(0, 1'b1, port_addr(0, 2, 9), 4'hf, 32'hdead_beef);
        wait_idle();
        fork
            issue(0, 1'b0, port_addr(0, 2, 9), 4'h0, '0);
            issue(1, 1'b0, port_addr(0, 2, 9), 4'h0, '0);
            issue(2, 1'b0, port_addr(0, 2, 9), 4'h0, '0);
            issue(3, 1'b0, port_addr(0, 2, 9), 4'h0, '0);
        join
        wait_idle();
        end_test();

        start_test("backpressure");
        stall[2] = 1'b1;
        fork
            read_burst(0, 1, 3);
            read_burst(1, 2, 3);
            read_burst(2, 0, 3);
            read_burst(3, 3, 3);
            begin
                repeat (20 + next_random() % 16) @(posedge clk);
                for (int p = 0; p < NP; p++) begin
                    others_done_a: assert (p == 2 || returned[p] == issued[p]) else begin
                        errors++;
                        $display("Port %0d stalled while port 2 was held", p);
                    end
                end
                stall[2] = 1'b0;
            end
        join
        wait_idle();
        end_test();

        start_test("random_mix");
        bp_random = 1'b1;
        fork
            random_ops(0, 100);
            random_ops(1, 100);
            random_ops(2, 100);
            random_ops(3, 100);
        join
        wait_idle();
        bp_random = 1'b0;
        end_test();

        $display("Tests: %0d, responses checked: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (RUN_OPS * 20) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", RUN_OPS * 20);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/lmem_pkg.sv
hw/lmem_stream_if.sv
hw/lmem_xbar.sv
hw/lmem_bank.sv
hw/lmem_top.sv
bench/lmem_tb.sv

// File: hw/lmem_bank.sv
`timescale 1ns/100ps
`default_nettype none

module lmem_bank #(
    parameter int NUM_BANKS      = 4,
    parameter int WORDS_PER_BANK = 256,
    parameter int REQ_SEL_WIDTH  = 2
) (
    input logic        clk,
    input logic        reset,
    lmem_stream_if.dst req,
    lmem_stream_if.src rsp
);

    localparam int BANK_SEL_BITS  = $clog2(NUM_BANKS);
    localparam int BANK_ADDR_W    = $clog2(WORDS_PER_BANK);
    localparam int USED_ADDR_BITS = BANK_SEL_BITS + BANK_ADDR_W;

    lmem_pkg::lmem_word_t     mem [WORDS_PER_BANK];
    logic [BANK_ADDR_W-1:0]   bank_addr;
    logic                     wr_fire;
    logic                     rd_fire;
    logic                     hazard;
    logic                     last_wr_q;
    logic [BANK_ADDR_W-1:0]   last_wr_addr_q;

    // RAM output register
    logic                     rd_valid_q;
    lmem_pkg::lmem_word_t     rd_data_q;
    lmem_pkg::lmem_tag_t      rd_tag_q;
    logic [REQ_SEL_WIDTH-1:0] rd_sel_q;
    logic                     rd_move;
    logic                     rd_free;

    logic                     buf_valid_q;
    lmem_pkg::lmem_rsp_t      buf_q;
    logic [REQ_SEL_WIDTH-1:0] buf_sel_q;

    assign bank_addr = req.data.addr[BANK_SEL_BITS +: BANK_ADDR_W];

    // Read right after a write to the same word waits one cycle
    assign hazard = last_wr_q && !req.data.rw && (bank_addr == last_wr_addr_q);

    assign rd_move   = rd_valid_q && (!buf_valid_q || rsp.ready);
    assign rd_free   = !rd_valid_q || rd_move;
    assign req.ready = req.data.rw || (rd_free && !hazard);
    assign wr_fire   = req.valid && req.ready && req.data.rw;
    assign rd_fire   = req.valid && req.ready && !req.data.rw;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int b = 0; b < lmem_pkg::LMEM_WORD_BYTES; b++) begin
                if (req.data.byteen[b]) begin
                    mem[bank_addr][b*8 +: 8] <= req.data.data[b*8 +: 8];
                end
            end
        end
        if (rd_fire) begin
            rd_data_q <= mem[bank_addr];
            rd_tag_q  <= req.data.tag;
            rd_sel_q  <= req.sel;
        end
        if (rd_move) begin
            buf_q     <= '{data: rd_data_q, tag: rd_tag_q};
            buf_sel_q <= rd_sel_q;
        end
        last_wr_addr_q <= bank_addr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_wr_q   <= 1'b0;
            rd_valid_q  <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            last_wr_q <= wr_fire;
            if (rd_free) begin
                rd_valid_q <= rd_fire;
            end
            if (rd_move) begin
                buf_valid_q <= 1'b1;
            end else if (rsp.ready) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    assign rsp.valid = buf_valid_q;
    assign rsp.data  = buf_q;
    assign rsp.sel   = buf_sel_q;

    rd_after_wr_a: assert property (@(posedge clk) disable iff (reset)
        wr_fire |=> !(rd_fire && (bank_addr == $past(bank_addr))));

    addr_range_a: assert property (@(posedge clk) disable iff (reset)
        req.valid |-> (req.data.addr >> USED_ADDR_BITS) == '0);

endmodule

`default_nettype wire

// File: hw/lmem_pkg.sv
`default_nettype none

package lmem_pkg;

    localparam int LMEM_WORD_BYTES = 4;

    typedef logic [LMEM_WORD_BYTES*8-1:0] lmem_word_t;
    typedef logic [LMEM_WORD_BYTES-1:0]   lmem_byteen_t;

    // Word address, low bits select the bank
    typedef logic [15:0] lmem_addr_t;

    typedef logic [7:0] lmem_tag_t;

    // 61 bits
    typedef struct packed {
        logic         rw;
        lmem_addr_t   addr;
        lmem_byteen_t byteen;
        lmem_word_t   data;
        lmem_tag_t    tag;
    } lmem_req_t;

    // 40 bits, reads only
    typedef struct packed {
        lmem_word_t data;
        lmem_tag_t  tag;
    } lmem_rsp_t;

endpackage

`default_nettype wire

// File: hw/lmem_stream_if.sv
`timescale 1ns/100ps
`default_nettype none

interface lmem_stream_if #(
    parameter type T         = logic,
    parameter int  SEL_WIDTH = 1
);

    logic                 valid;
    logic                 ready;
    T                     data;
    // Routing index, meaning depends on the stream
    logic [SEL_WIDTH-1:0] sel;

    modport src (
        output valid,
        output data,
        output sel,
        input  ready
    );

    modport dst (
        input  valid,
        input  data,
        input  sel,
        output ready
    );

endinterface

`default_nettype wire

// File: hw/lmem_top.sv
`timescale 1ns/100ps
`default_nettype none

module lmem_top #(
    parameter int NUM_REQS       = 4,
    parameter int NUM_BANKS      = 4,
    parameter int WORDS_PER_BANK = 256
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid [NUM_REQS],
    input  logic                   req_rw [NUM_REQS],
    input  lmem_pkg::lmem_addr_t   req_addr [NUM_REQS],
    input  lmem_pkg::lmem_byteen_t req_byteen [NUM_REQS],
    input  lmem_pkg::lmem_word_t   req_data [NUM_REQS],
    input  lmem_pkg::lmem_tag_t    req_tag [NUM_REQS],
    output logic                   req_ready [NUM_REQS],
    output logic                   rsp_valid [NUM_REQS],
    output lmem_pkg::lmem_word_t   rsp_data [NUM_REQS],
    output lmem_pkg::lmem_tag_t    rsp_tag [NUM_REQS],
    input  logic                   rsp_ready [NUM_REQS]
);

    localparam int REQ_SEL_W  = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1;
    localparam int BANK_SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

    lmem_stream_if #(.T(lmem_pkg::lmem_req_t), .SEL_WIDTH(BANK_SEL_W)) req_if [NUM_REQS] ();
    lmem_stream_if #(.T(lmem_pkg::lmem_req_t), .SEL_WIDTH(REQ_SEL_W)) bank_req_if [NUM_BANKS] ();
    lmem_stream_if #(.T(lmem_pkg::lmem_rsp_t), .SEL_WIDTH(REQ_SEL_W)) bank_rsp_if [NUM_BANKS] ();
    lmem_stream_if #(.T(lmem_pkg::lmem_rsp_t), .SEL_WIDTH(BANK_SEL_W)) rsp_if [NUM_REQS] ();

    for (genvar i = 0; i < NUM_REQS; i++) begin : port_gen
        assign req_if[i].valid = req_valid[i];
        assign req_if[i].data  = '{
            rw:     req_rw[i],
            addr:   req_addr[i],
            byteen: req_byteen[i],
            data:   req_data[i],
            tag:    req_tag[i]
        };
        // Bank index from the low word-address bits
        assign req_if[i].sel = BANK_SEL_W'(req_addr[i] & lmem_pkg::lmem_addr_t'(NUM_BANKS - 1));
        assign req_ready[i]  = req_if[i].ready;

        assign rsp_valid[i]    = rsp_if[i].valid;
        assign rsp_data[i]     = rsp_if[i].data.data;
        assign rsp_tag[i]      = rsp_if[i].data.tag;
        assign rsp_if[i].ready = rsp_ready[i];
    end

    lmem_xbar #(
        .NUM_INPUTS  (NUM_REQS),
        .NUM_OUTPUTS (NUM_BANKS),
        .T           (lmem_pkg::lmem_req_t),
        .OUT_REG     (1)
    ) req_xbar (
        .clk         (clk),
        .reset       (reset),
        .in_streams  (req_if),
        .out_streams (bank_req_if)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : bank_gen
        lmem_bank #(
            .NUM_BANKS      (NUM_BANKS),
            .WORDS_PER_BANK (WORDS_PER_BANK),
            .REQ_SEL_WIDTH  (REQ_SEL_W)
        ) banks (
            .clk   (clk),
            .reset (reset),
            .req   (bank_req_if[b]),
            .rsp   (bank_rsp_if[b])
        );
    end

    lmem_xbar #(
        .NUM_INPUTS  (NUM_BANKS),
        .NUM_OUTPUTS (NUM_REQS),
        .T           (lmem_pkg::lmem_rsp_t),
        .OUT_REG     (0)
    ) rsp_xbar (
        .clk         (clk),
        .reset       (reset),
        .in_streams  (bank_rsp_if),
        .out_streams (rsp_if)
    );

endmodule

`default_nettype wire

// File: hw/lmem_xbar.sv
`timescale 1ns/100ps
`default_nettype none

module lmem_xbar #(
    parameter int  NUM_INPUTS  = 4,
    parameter int  NUM_OUTPUTS = 4,
    parameter type T           = logic,
    parameter int  OUT_REG     = 0
) (
    input logic        clk,
    input logic        reset,
    lmem_stream_if.dst in_streams [NUM_INPUTS],
    lmem_stream_if.src out_streams [NUM_OUTPUTS]
);

    localparam int IN_SEL_W  = (NUM_OUTPUTS > 1) ? $clog2(NUM_OUTPUTS) : 1;
    localparam int OUT_SEL_W = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;

    logic                  in_valid [NUM_INPUTS];
    logic [IN_SEL_W-1:0]   in_sel [NUM_INPUTS];
    T                      in_data [NUM_INPUTS];
    logic [NUM_INPUTS-1:0] in_ready;

    logic [NUM_INPUTS-1:0] grant [NUM_OUTPUTS];
    logic                  accept [NUM_OUTPUTS];

    for (genvar i = 0; i < NUM_INPUTS; i++) begin : in_gen
        assign in_valid[i]         = in_streams[i].valid;
        assign in_sel[i]           = in_streams[i].sel;
        assign in_data[i]          = in_streams[i].data;
        assign in_streams[i].ready = in_ready[i];
    end

    always_comb begin
        in_ready = '0;
        for (int o = 0; o < NUM_OUTPUTS; o++) begin
            in_ready = in_ready | (grant[o] & {NUM_INPUTS{accept[o]}});
        end
    end

    for (genvar o = 0; o < NUM_OUTPUTS; o++) begin : out_gen
        logic [NUM_INPUTS-1:0] request;
        logic                  arb_valid;
        logic [OUT_SEL_W-1:0]  pick;
        logic [OUT_SEL_W-1:0]  win;
        logic                  hold_q;
        logic [OUT_SEL_W-1:0]  hold_idx_q;

        // Lowest index wins
        always_comb begin
            pick = '0;
            for (int i = NUM_INPUTS - 1; i >= 0; i--) begin
                request[i] = in_valid[i] && (in_sel[i] == IN_SEL_W'(o));
                if (request[i]) begin
                    pick = OUT_SEL_W'(i);
                end
            end
        end

        // Keep the stalled winner so the output does not switch before its transfer
        assign win       = hold_q ? hold_idx_q : pick;
        assign arb_valid = |request;
        assign grant[o]  = arb_valid ? (NUM_INPUTS'(1) << win) : '0;

        always_ff @(posedge clk) begin
            if (reset) begin
                hold_q <= 1'b0;
            end else begin
                hold_q <= arb_valid && !accept[o];
            end
            hold_idx_q <= win;
        end

        if (OUT_REG != 0) begin : reg_gen
            logic                 full_q;
            T                     data_q;
            logic [OUT_SEL_W-1:0] sel_q;

            assign accept[o] = !full_q || out_streams[o].ready;

            always_ff @(posedge clk) begin
                if (reset) begin
                    full_q <= 1'b0;
                end else if (accept[o]) begin
                    full_q <= arb_valid;
                end
            end

            always_ff @(posedge clk) begin
                if (accept[o] && arb_valid) begin
                    data_q <= in_data[win];
                    sel_q  <= win;
                end
            end

            assign out_streams[o].valid = full_q;
            assign out_streams[o].data  = data_q;
            assign out_streams[o].sel   = sel_q;
        end else begin : comb_gen
            assign accept[o]            = out_streams[o].ready;
            assign out_streams[o].valid = arb_valid;
            assign out_streams[o].data  = in_data[win];
            assign out_streams[o].sel   = win;
        end

        out_hold_a: assert property (@(posedge clk) disable iff (reset)
            out_streams[o].valid && !out_streams[o].ready
            |=> out_streams[o].valid && $stable(out_streams[o].data));
    end

endmodule

`default_nettype wire
